// File: icache.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_ram.sv
verilog/icache_refill.sv
verilog/icache_controller.sv
verilog/icache.sv
verification/icache_props.sv
verification/icache_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the icache testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
		-f icache.f -Mdir obj_dir -o icache_sim
	./obj_dir/icache_sim | tee sim.log
	@grep -q '^All tests passed!$$' sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: verification/icache_trace.txt
# name  vaddr(hex)  paddr(hex)  tlb_wait(cycles)  outcome(hit/miss)  stalls(cycles)
# index comes from vaddr[8:4], tag from paddr[31:9]
cold_miss        00000120 80004120 0 miss 0
repeat_hit       00000120 80004120 0 hit  0
same_line_word   0000012c 8000412c 0 hit  0
evict_a_miss     00000050 12340050 0 miss 0
evict_b_miss     00000050 12340250 0 miss 0
evict_a_again    00000058 12340058 0 miss 0
evict_b_again    0000005c 1234025c 0 miss 0
evict_b_hit      00000054 12340254 0 hit  0
tlb_wait_hit     00000124 80004124 3 hit  0
tlb_wait_miss    000001f0 00ff01f0 2 miss 0
tlb_wait_refetch 000001f8 00ff01f8 1 hit  0
stall_hit        00000128 80004128 0 hit  4
stall_miss       00000070 0abcd3f0 0 miss 3
virt_index_hit   0000007c 0abcd3fc 2 hit  2
same_tag_new_set 00000080 80004080 0 miss 0
same_tag_new_hit 00000084 80004084 0 hit  1
long_stall_miss  00000300 7fff0300 1 miss 6
cold_again_hit   00000120 80004120 0 hit  0

// File: verification/icache_tb.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int RESET_CYCLES    = 10;
    localparam int MAX_GRANT_DELAY = 5;
    localparam int MAX_BUSY        = 2;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      req_valid;
    logic                      req_ready;
    logic [`ICACHE_ADDR_W-1:0] req_address;
    logic                      dp_valid;
    logic                      dp_ready;
    line_t                     dp_read_data;
    logic [`ICACHE_ADDR_W-1:0] phys_addr;
    logic                      tlb_hit;
    logic [`ICACHE_ADDR_W-1:0] mem_addr;
    logic                      mem_req;
    logic                      mem_data_valid;
    logic [`ICACHE_BUS_W-1:0]  mem_data;
    logic                      grant_in;
    logic                      grant_out;
    logic                      bus_busy_in;
    logic                      bus_busy_out;

    // one entry per trace line
    string                     t_name[$];
    logic [`ICACHE_ADDR_W-1:0] t_vaddr[$];
    logic [`ICACHE_ADDR_W-1:0] t_paddr[$];
    int                        t_tlb_wait[$];
    logic                      t_miss[$];
    int                        t_stall[$];

    int errors      = 0;
    int test_errors = 0;
    int passed      = 0;
    int cycles      = 0;
    int limit       = 0;

    icache u_icache (.*);

    // bus rules on the refill unit, handshake rules on the controller
    bind icache_refill icache_props u_props (
        .*,
        .dp_valid     (1'b0),
        .dp_ready     (1'b1),
        .dp_read_data ('0),
        .req_ready    (1'b0)
    );
    bind icache_controller icache_props u_props (
        .*,
        .mem_req      (1'b0),
        .bus_busy_out (1'b0),
        .grant_in     (1'b0),
        .bus_busy_in  (1'b0),
        .grant_out    (1'b0)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the cache stopped responding", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [`ICACHE_ADDR_W-1:0] line_base(input logic [`ICACHE_ADDR_W-1:0] a);
        return {a[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    endfunction

    // memory contents, inverted address above the address
    function automatic logic [`ICACHE_BUS_W-1:0] mem_word(input logic [`ICACHE_ADDR_W-1:0] a);
        return {~a[15:0], a[15:0]};
    endfunction

    function automatic line_t line_for(input logic [`ICACHE_ADDR_W-1:0] paddr);
        line_t l;
        for (int k = 0; k < `ICACHE_BEATS; k++) begin
            l[k] = mem_word(line_base(paddr) + 4 * k);
        end
        return l;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        test_errors++;
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            report_error($sformatf("mismatch %s: line expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [`ICACHE_ADDR_W-1:0] exp,
                              input logic [`ICACHE_ADDR_W-1:0] act);
        if (act !== exp) begin
            report_error($sformatf("mismatch %s: mem_addr expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_outcome(input string name, input logic exp_miss, input logic act_miss);
        if (act_miss !== exp_miss) begin
            report_error($sformatf("mismatch %s: outcome expected %s actual %s", name,
                                   exp_miss ? "miss" : "hit", act_miss ? "miss" : "hit"));
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            report_error($sformatf("mismatch %s: hit latency expected %0d actual %0d", name,
                                   exp, act));
        end
    endtask

    task automatic run_test(input int i);
        string                     name;
        line_t                     exp_line;
        logic [`ICACHE_ADDR_W-1:0] base;
        int                        gdelay;
        int                        busy_len;
        int                        k;
        int                        beat;
        logic                      saw_req;
        name        = t_name[i];
        exp_line    = line_for(t_paddr[i]);
        base        = line_base(t_paddr[i]);
        gdelay      = $urandom_range(MAX_GRANT_DELAY, 0);
        busy_len    = $urandom_range(MAX_BUSY, 1);
        test_errors = 0;
        k           = 0;
        beat        = 0;
        saw_req     = 1'b0;

        // idle cache hands the grant on
        grant_in = 1'b1;
        @(negedge clk);
        if (grant_out !== 1'b1) report_error("grant_out did not follow grant_in while idle");
        grant_in    = 1'b0;
        req_valid   = 1'b1;
        req_address = t_vaddr[i];
        phys_addr   = t_paddr[i];
        tlb_hit     = (t_tlb_wait[i] == 0);
        repeat (t_tlb_wait[i]) begin
            @(negedge clk);
            if (req_ready !== 1'b1) report_error("request accepted while tlb_hit was low");
        end
        tlb_hit = 1'b1;
        if (req_ready !== 1'b1) report_error("req_ready low while the cache is idle");
        @(negedge clk);
        if (req_ready !== 1'b0) report_error("request with tlb_hit high was not accepted");
        req_valid = 1'b0;
        tlb_hit   = 1'b0;

        // serve the bus until the response appears
        do begin
            @(negedge clk);
            k++;
            if (dp_valid !== 1'b1) begin
                if (grant_in && beat < `ICACHE_BEATS && grant_out !== 1'b0)
                    report_error("grant_out passed on during a refill");
                if (mem_req === 1'b1) begin
                    if (beat == 0 && (bus_busy_in || !grant_in))
                        report_error("bus taken without a free grant");
                    if (beat >= `ICACHE_BEATS) report_error("more than four beats on the bus");
                    if (bus_busy_out !== 1'b1) report_error("bus_busy_out low during a bus beat");
                    saw_req = 1'b1;
                    check_addr(name, base + 4 * beat, mem_addr);
                    mem_data       = mem_word(mem_addr);
                    mem_data_valid = 1'b1;
                    beat++;
                end else begin
                    if (bus_busy_out !== 1'b0)
                        report_error("bus_busy_out high with no bus request");
                    mem_data_valid = 1'b0;
                end
                // grant after a random delay and a busy pulse
                bus_busy_in = 1'b0;
                if (beat >= `ICACHE_BEATS) begin
                    grant_in = 1'b0;
                end else if (k >= 2 && gdelay > 0) begin
                    gdelay--;
                end else if (k >= 2 && busy_len > 0) begin
                    grant_in    = 1'b1;
                    bus_busy_in = 1'b1;
                    busy_len--;
                end else if (k >= 2) begin
                    grant_in = 1'b1;
                end
            end
        end while (dp_valid !== 1'b1);
        grant_in    = 1'b0;
        bus_busy_in = 1'b0;

        check_outcome(name, t_miss[i], saw_req);
        if (!t_miss[i]) check_latency(name, 2, k);
        check_line(name, exp_line, dp_read_data);
        if (req_ready !== 1'b0) report_error("req_ready high while the response is pending");
        repeat (t_stall[i]) begin
            @(negedge clk);
            if (dp_valid !== 1'b1) report_error("dp_valid dropped while dp_ready was low");
            check_line(name, exp_line, dp_read_data);
        end
        dp_ready = 1'b1;
        @(negedge clk);
        dp_ready = 1'b0;
        if (dp_valid !== 1'b0 || req_ready !== 1'b1)
            report_error("response did not transfer with dp_ready high");

        if (test_errors == 0) begin
            passed++;
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d error(s)", name, test_errors);
        end
        errors += test_errors;
    endtask

    initial begin
        int                        fd;
        int                        tw;
        int                        st;
        string                     line;
        string                     name;
        string                     outcome;
        logic [`ICACHE_ADDR_W-1:0] va;
        logic [`ICACHE_ADDR_W-1:0] pa;
        void'($urandom(32'hdf99_d04f));
        rst            = 1'b1;
        req_valid      = 1'b0;
        req_address    = '0;
        phys_addr      = '0;
        tlb_hit        = 1'b0;
        dp_ready       = 1'b0;
        mem_data_valid = 1'b0;
        mem_data       = '0;
        grant_in       = 1'b0;
        bus_busy_in    = 1'b0;

        fd = $fopen("verification/icache_trace.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%s %h %h %d %s %d", name, va, pa, tw, outcome, st) == 6) begin
                    t_name.push_back(name);
                    t_vaddr.push_back(va);
                    t_paddr.push_back(pa);
                    t_tlb_wait.push_back(tw);
                    t_miss.push_back(outcome == "miss");
                    t_stall.push_back(st);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        if (t_name.size() == 0) begin
            errors++;
            $display("no tests read from verification/icache_trace.txt");
        end

        // cycle budget per request, worst case grant and stalls
        limit = RESET_CYCLES + 5;
        foreach (t_name[i]) begin
            limit += 20 + MAX_GRANT_DELAY + MAX_BUSY + t_tlb_wait[i] + t_stall[i];
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        if (req_ready !== 1'b1 || dp_valid !== 1'b0 || mem_req !== 1'b0 ||
            bus_busy_out !== 1'b0) begin
            errors++;
            $display("outputs not at their reset values after reset");
        end
        rst = 1'b0;

        foreach (t_name[i]) run_test(i);

        $display("tests %0d, passed %0d, failed %0d, errors %0d", t_name.size(), passed,
                 t_name.size() - passed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verification/icache_props.sv
`timescale 1ns/1ps

// protocol rules, bound into the refill unit and the controller
module icache_props (
    input logic              clk,
    input logic              rst,
    input logic              mem_req,
    input logic              bus_busy_out,
    input logic              grant_in,
    input logic              bus_busy_in,
    input logic              grant_out,
    input logic              dp_valid,
    input logic              dp_ready,
    input icache_pkg::line_t dp_read_data,
    input logic              req_ready
);

    // bus marked busy while requested, owned only after a free grant
    a_req_busy: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> bus_busy_out && ($past(mem_req) || $past(grant_in && !bus_busy_in)))
        else $error("mem_req high without bus_busy_out or without a free grant");

    a_grant_blocked: assert property (@(posedge clk) disable iff (rst)
        bus_busy_out |-> !grant_out)
        else $error("grant_out high while the bus is owned");

    // held response keeps its line
    a_resp_stable: assert property (@(posedge clk) disable iff (rst)
        dp_valid && !dp_ready |=> dp_valid && $stable(dp_read_data))
        else $error("response changed or dropped under back-pressure");

    a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
        dp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending");

endmodule

// File: verilog/icache.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache (
    input  logic                      clk,
    input  logic                      rst,

    // fetch stage
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [`ICACHE_ADDR_W-1:0] req_address,
    output logic                      dp_valid,
    input  logic                      dp_ready,
    output icache_pkg::line_t         dp_read_data,

    // from the TLB
    input  logic [`ICACHE_ADDR_W-1:0] phys_addr,
    input  logic                      tlb_hit,

    // shared bus, read only
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    output logic                      mem_req,
    input  logic                      mem_data_valid,
    input  logic [`ICACHE_BUS_W-1:0]  mem_data,

    // arbitration chain
    input  logic                      grant_in,
    output logic                      grant_out,
    input  logic                      bus_busy_in,
    output logic                      bus_busy_out
);
    import icache_pkg::*;

    logic [`ICACHE_INDEX_W-1:0] rd_idx;
    logic [`ICACHE_INDEX_W-1:0] wr_idx;
    logic [`ICACHE_INDEX_W-1:0] ram_idx;
    logic                       wr_en;
    logic                       start;
    tag_t                       tag_wr;
    tag_t                       tag_rd;
    line_t                      line_wr;
    line_t                      line_rd;
    fetch_req_t                 fetch;
    fill_t                      fill;

    // both arrays share one address port
    assign ram_idx = wr_en ? wr_idx : rd_idx;

    icache_ram #(
        .entry_t (tag_t),
        .DEPTH   (`ICACHE_SETS)
    ) u_tag_ram (
        .clk   (clk),
        .idx   (ram_idx),
        .we    (wr_en),
        .wdata (tag_wr),
        .rdata (tag_rd)
    );

    icache_ram #(
        .entry_t (line_t),
        .DEPTH   (`ICACHE_SETS)
    ) u_data_ram (
        .clk   (clk),
        .idx   (ram_idx),
        .we    (wr_en),
        .wdata (line_wr),
        .rdata (line_rd)
    );

    icache_controller u_controller (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_address  (req_address),
        .phys_addr    (phys_addr),
        .tlb_hit      (tlb_hit),
        .dp_valid     (dp_valid),
        .dp_ready     (dp_ready),
        .dp_read_data (dp_read_data),
        .rd_idx       (rd_idx),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .tag_wr       (tag_wr),
        .line_wr      (line_wr),
        .tag_rd       (tag_rd),
        .line_rd      (line_rd),
        .start        (start),
        .fetch        (fetch),
        .fill         (fill)
    );

    icache_refill u_refill (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .req            (fetch),
        .fill           (fill),
        .mem_addr       (mem_addr),
        .mem_req        (mem_req),
        .mem_data_valid (mem_data_valid),
        .mem_data       (mem_data),
        .grant_in       (grant_in),
        .grant_out      (grant_out),
        .bus_busy_in    (bus_busy_in),
        .bus_busy_out   (bus_busy_out)
    );

endmodule

// File: verilog/icache_controller.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic [`ICACHE_ADDR_W-1:0]  req_address,
    input  logic [`ICACHE_ADDR_W-1:0]  phys_addr,
    input  logic                       tlb_hit,
    output logic                       dp_valid,
    input  logic                       dp_ready,
    output icache_pkg::line_t          dp_read_data,
    output logic [`ICACHE_INDEX_W-1:0] rd_idx,
    output logic                       wr_en,
    output logic [`ICACHE_INDEX_W-1:0] wr_idx,
    output icache_pkg::tag_t           tag_wr,
    output icache_pkg::line_t          line_wr,
    input  icache_pkg::tag_t           tag_rd,
    input  icache_pkg::line_t          line_rd,
    output logic                       start,
    output icache_pkg::fetch_req_t     fetch,
    input  icache_pkg::fill_t          fill
);
    import icache_pkg::*;

    localparam int TAG_LSB = `ICACHE_OFFSET_W + `ICACHE_INDEX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_RESPOND
    } state_t;

    state_t                   state;
    fetch_req_t               req_q;
    tag_t                     req_tag;
    line_t                    resp_q;
    line_t                    resp_next;
    logic [`ICACHE_SETS-1:0]  valid_q;
    logic                     rd_pend;
    logic                     accept;
    logic                     hit;
    logic                     lookup_done;

    assign accept  = req_ready && req_valid && tlb_hit;
    assign req_tag = req_q.paddr[`ICACHE_ADDR_W-1:TAG_LSB];
    assign rd_idx  = req_q.vaddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // arrays read one edge after acceptance, decide on the cycle after
    assign lookup_done = (state == S_LOOKUP) && !rd_pend;
    assign hit         = valid_q[rd_idx] && (tag_rd == req_tag);
    assign start       = lookup_done && !hit;

    // fill writes both arrays in the same cycle
    assign wr_en   = (state == S_FILL) && fill.valid;
    assign wr_idx  = fill.index;
    assign tag_wr  = req_tag;
    assign line_wr = fill.line;

    assign fetch = req_q;

    // response comes from the refill on a miss, else from the data array
    assign resp_next = (state == S_FILL) ? fill.line : line_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            rd_pend <= 1'b0;
            valid_q <= '0;
        end else begin
            rd_pend <= accept;
            if (wr_en) begin
                valid_q[wr_idx] <= 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (lookup_done) begin
                        state <= hit ? S_RESPOND : S_FILL;
                    end
                end
                S_FILL: begin
                    if (fill.valid) begin
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    if (dp_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.vaddr <= req_address;
            req_q.paddr <= phys_addr;
        end
        if ((lookup_done && hit) || wr_en) begin
            resp_q <= resp_next;
        end
    end

    // one fetch in flight at a time
    assign req_ready    = (state == S_IDLE);
    assign dp_valid     = (state == S_RESPOND);
    assign dp_read_data = resp_q;

endmodule

// File: verilog/icache_refill.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_refill (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  icache_pkg::fetch_req_t    req,
    output icache_pkg::fill_t         fill,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    output logic                      mem_req,
    input  logic                      mem_data_valid,
    input  logic [`ICACHE_BUS_W-1:0]  mem_data,
    input  logic                      grant_in,
    output logic                      grant_out,
    input  logic                      bus_busy_in,
    output logic                      bus_busy_out
);
    import icache_pkg::*;

    localparam int CNT_W = $clog2(`ICACHE_BEATS);

    // S_DONE doubles as the resting state
    typedef enum logic [1:0] {
        S_WAIT,
        S_BEAT,
        S_DONE
    } state_t;

    state_t                     state;
    logic [CNT_W-1:0]           beat_q;
    logic [`ICACHE_ADDR_W-1:0]  addr_q;
    logic [`ICACHE_INDEX_W-1:0] idx_q;
    line_t                      words_q;
    logic                       fill_vld;
    logic                       take_bus;
    logic                       last_beat;

    // grant seen and nobody else on the bus
    assign take_bus  = (state == S_WAIT) && grant_in && !bus_busy_in;
    assign last_beat = (state == S_BEAT) && mem_data_valid &&
                       (beat_q == CNT_W'(`ICACHE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_DONE;
            beat_q   <= '0;
            fill_vld <= 1'b0;
        end else begin
            fill_vld <= last_beat;
            case (state)
                S_DONE: begin
                    if (start) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (take_bus) begin
                        state  <= S_BEAT;
                        beat_q <= '0;
                    end
                end
                S_BEAT: begin
                    if (mem_data_valid) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (last_beat) begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    state <= S_DONE;
                end
            endcase
        end
    end

    // line base on start, then one word further per beat
    always_ff @(posedge clk) begin
        if (start && (state == S_DONE)) begin
            addr_q <= {req.paddr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                       {`ICACHE_OFFSET_W{1'b0}}};
            idx_q  <= req.vaddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        end else if ((state == S_BEAT) && mem_data_valid) begin
            addr_q <= addr_q + `ICACHE_ADDR_W'(4);
        end
    end

    // beat k lands in word k
    always_ff @(posedge clk) begin
        if ((state == S_BEAT) && mem_data_valid) begin
            words_q[beat_q] <= mem_data;
        end
    end

    always_comb begin
        fill.valid = fill_vld;
        fill.index = idx_q;
        fill.line  = words_q;
    end

    assign mem_addr     = addr_q;
    assign mem_req      = (state == S_BEAT);
    assign bus_busy_out = (state == S_BEAT);

    // hand the grant on only while idle
    assign grant_out = (state == S_DONE) ? grant_in : 1'b0;

endmodule

// File: verilog/icache_ram.sv
`timescale 1ns/1ps
`include "icache_defs.svh"

// single-port array, one entry per set
// same module holds the tags and the lines
module icache_ram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = `ICACHE_SETS
) (
    input  logic                       clk,
    input  logic [`ICACHE_INDEX_W-1:0] idx,
    input  logic                       we,
    input  entry_t                     wdata,
    output entry_t                     rdata
);

    entry_t mem [DEPTH];

    // write has priority over the read port
    // rdata keeps its old value on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end else begin
            rdata <= mem[idx];
        end
    end

endmodule

// File: verilog/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    // accepted fetch, virtual address for the index, physical for the tag
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] vaddr;
        logic [`ICACHE_ADDR_W-1:0] paddr;
    } fetch_req_t;

    // one line as bus words, word 0 in the low bits
    typedef logic [`ICACHE_LINE_W/`ICACHE_BUS_W-1:0][`ICACHE_BUS_W-1:0] line_t;

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    // finished refill, valid strobes for one cycle
    typedef struct packed {
        logic                       valid;
        logic [`ICACHE_INDEX_W-1:0] index;
        line_t                      line;
    } fill_t;

endpackage

// File: verilog/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// cache geometry
// 32 sets of 16-byte lines, direct mapped
`define ICACHE_SETS     32
`define ICACHE_INDEX_W  5
`define ICACHE_OFFSET_W 4
`define ICACHE_TAG_W    23

// physical address width
`define ICACHE_ADDR_W   32

// shared bus and line widths
`define ICACHE_BUS_W    32
`define ICACHE_LINE_W   128

// bus words per line
`define ICACHE_BEATS    4

`endif
